//--- source/uart_frame_pkg.sv
//##########################################################################
// shared types and constants of the framed-string UART transceiver
// wishbone request/response structs, buffer regions and the delimiter
// byte. import it inside a module body, use scoped names in module headers
//##########################################################################
package uart_frame_pkg;

	// master side of a wishbone classic transfer
	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		logic [7:0]	adr;
		logic [7:0]	dat;
	} wb_req_t;

	// slave side, read data valid with ack
	typedef struct packed {
		logic		ack;
		logic [7:0]	dat;
	} wb_rsp_t;

	// frame delimiter, sent twice at each end of a frame
	localparam logic [7:0] FRAME_DELIM = 8'h26;

	// message buffer layout
	localparam logic [7:0] TX_BASE = 8'd0;
	localparam logic [7:0] RX_BASE = 8'd128;

	// 8-bit addresses cover the whole memory
	localparam int BUF_DEPTH = 256;

endpackage

//--- source/uart_tx.sv
//##########################################################################
// 8N1 serializer, LSB first, one bit every CLKS_PER_BIT clocks
// a byte is taken when tx_valid and tx_ready are both high
//##########################################################################
module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic		sys_clk,
	input  logic		sys_rst_n,
	input  logic		tx_valid,
	input  logic [7:0]	tx_data,
	output logic		tx_ready,
	output logic		txd
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t			state;
	logic [CNT_W-1:0]	baud_cnt;
	logic [2:0]		bit_idx;
	logic [7:0]		shift;
	logic			bit_end;

	assign bit_end  = (baud_cnt == BIT_LAST);
	assign tx_ready = (state == S_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			txd      <= 1'b1;
		end else begin
			baud_cnt <= (state == S_IDLE || bit_end) ? '0 : baud_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					if (tx_valid) begin
						state <= S_START;
						txd   <= 1'b0;
					end
				end
				S_START: begin
					if (bit_end) begin
						state   <= S_DATA;
						bit_idx <= '0;
						txd     <= shift[0];
					end
				end
				S_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
							txd   <= 1'b1;
						end else begin
							txd <= shift[1];
						end
					end
				end
				default: begin
					// stop bit, line already high
					if (bit_end)
						state <= S_IDLE;
				end
			endcase
		end
	end

	// data byte, shifted out towards bit 0
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && tx_valid)
			shift <= tx_data;
		else if (state == S_DATA && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

	idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == S_IDLE) |-> txd)
		else $error("txd low while serializer idle");

endmodule

//--- source/uart_rx.sv
//##########################################################################
// 8N1 deserializer with a two-flop input synchronizer
// bits are sampled at mid-bit; rx_valid strobes for one clock with the
// byte at the middle of the stop bit
//##########################################################################
module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic		sys_clk,
	input  logic		sys_rst_n,
	input  logic		rxd,
	output logic		rx_valid,
	output logic [7:0]	rx_byte
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t			state;
	logic			rxd_m;
	logic			rxd_s;
	logic			rxd_d;
	logic			fall;
	logic [CNT_W-1:0]	cnt;
	logic [2:0]		bit_idx;
	logic [7:0]		shift;

	// line idles high, so the synchronizer resets to 1
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_m <= 1'b1;
			rxd_s <= 1'b1;
			rxd_d <= 1'b1;
		end else begin
			rxd_m <= rxd;
			rxd_s <= rxd_m;
			rxd_d <= rxd_s;
		end
	end

	assign fall = rxd_d & ~rxd_s;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			cnt      <= cnt + 1'b1;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (fall)
						state <= S_START;
				end
				S_START: begin
					if (cnt == HALF_LAST) begin
						// glitch rejection at start-bit midpoint
						state   <= rxd_s ? S_IDLE : S_DATA;
						cnt     <= '0;
						bit_idx <= '0;
					end
				end
				S_DATA: begin
					if (cnt == BIT_LAST) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end
				end
				default: begin
					if (cnt == BIT_LAST) begin
						// framing error drops the byte
						rx_valid <= rxd_s;
						state    <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && cnt == BIT_LAST)
			shift <= {rxd_s, shift[7:1]};
	end

	// shift register holds the byte until the next data bit
	assign rx_byte = shift;

endmodule

//--- source/frame_encoder.sv
//##########################################################################
// transmit side: on tx_start sends &&, the payload read from the transmit
// region of the buffer, then && through the serializer handshake
// tx_done pulses once the last stop bit has left the line
//##########################################################################
module frame_encoder #(
	parameter int MAX_LEN = 64
) (
	input  logic				sys_clk,
	input  logic				sys_rst_n,
	input  logic				tx_start,
	input  logic [7:0]			tx_length,
	output logic				tx_busy,
	output logic				tx_done,
	output uart_frame_pkg::wb_req_t		wb_req,
	input  uart_frame_pkg::wb_rsp_t		wb_rsp,
	output logic				byte_valid,
	output logic [7:0]			byte_data,
	input  logic				byte_ready
);

	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_OPEN1, S_OPEN2, S_FETCH, S_SEND, S_CLOSE1, S_CLOSE2, S_FINISH
	} state_t;

	state_t		state;
	logic [7:0]	len_q;
	logic [7:0]	idx_q;
	logic [7:0]	data_q;
	logic		hs;

	assign byte_valid = (state == S_OPEN1) || (state == S_OPEN2) || (state == S_SEND) ||
			    (state == S_CLOSE1) || (state == S_CLOSE2);
	assign byte_data  = (state == S_SEND) ? data_q : FRAME_DELIM;
	assign hs         = byte_valid && byte_ready;

	assign tx_busy = (state != S_IDLE);
	// serializer back to idle after the fourth delimiter
	assign tx_done = (state == S_FINISH) && byte_ready;

	always_comb begin
		wb_req = '0;
		if (state == S_FETCH) begin
			wb_req.cyc = 1'b1;
			wb_req.stb = 1'b1;
			wb_req.adr = TX_BASE + idx_q;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			len_q <= '0;
			idx_q <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (tx_start) begin
						len_q <= (tx_length > 8'(MAX_LEN)) ? 8'(MAX_LEN) : tx_length;
						idx_q <= '0;
						state <= S_OPEN1;
					end
				end
				S_OPEN1:  if (hs) state <= S_OPEN2;
				S_OPEN2:  if (hs) state <= (len_q == 8'd0) ? S_CLOSE1 : S_FETCH;
				S_FETCH:  if (wb_rsp.ack) state <= S_SEND;
				S_SEND: begin
					if (hs) begin
						idx_q <= idx_q + 8'd1;
						state <= (idx_q + 8'd1 == len_q) ? S_CLOSE1 : S_FETCH;
					end
				end
				S_CLOSE1: if (hs) state <= S_CLOSE2;
				S_CLOSE2: if (hs) state <= S_FINISH;
				default:  if (byte_ready) state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == S_FETCH && wb_rsp.ack)
			data_q <= wb_rsp.dat;
	end

	// encoder only reads, and only inside the transmit region
	fetch_in_tx_region: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb_req.cyc |-> !wb_req.we && (8'(wb_req.adr - TX_BASE) < 8'(MAX_LEN)))
		else $error("encoder access outside transmit region or with we set");

endmodule

//--- source/frame_decoder.sv
//##########################################################################
// receive side: hunts for && on the received byte stream, writes payload
// bytes to the receive region of the buffer and reports the length on
// the closing pair. a lone & or an overlong payload reports rx_error
//##########################################################################
module frame_decoder #(
	parameter int MAX_LEN = 64
) (
	input  logic				sys_clk,
	input  logic				sys_rst_n,
	input  logic				rx_valid,
	input  logic [7:0]			rx_byte,
	output uart_frame_pkg::wb_req_t		wb_req,
	input  uart_frame_pkg::wb_rsp_t		wb_rsp,
	output logic				rx_done,
	output logic				rx_error,
	output logic [7:0]			rx_length
);

	import uart_frame_pkg::*;

	typedef enum logic [2:0] {
		S_HUNT1, S_HUNT2, S_CONTENT, S_CLOSE2, S_WRITE
	} state_t;

	state_t		state;
	logic [7:0]	count_q;
	logic [7:0]	wdata_q;
	logic		is_delim;

	assign is_delim = (rx_byte == FRAME_DELIM);

	always_comb begin
		wb_req = '0;
		if (state == S_WRITE) begin
			wb_req.cyc = 1'b1;
			wb_req.stb = 1'b1;
			wb_req.we  = 1'b1;
			wb_req.adr = RX_BASE + count_q;
			wb_req.dat = wdata_q;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_HUNT1;
			count_q   <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
			rx_length <= '0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			case (state)
				S_HUNT1: begin
					if (rx_valid && is_delim)
						state <= S_HUNT2;
				end
				S_HUNT2: begin
					if (rx_valid) begin
						state   <= is_delim ? S_CONTENT : S_HUNT1;
						count_q <= '0;
					end
				end
				S_CONTENT: begin
					if (rx_valid) begin
						if (is_delim) begin
							state <= S_CLOSE2;
						end else if (count_q == 8'(MAX_LEN)) begin
							// one byte too many
							rx_error <= 1'b1;
							state    <= S_HUNT1;
						end else begin
							state <= S_WRITE;
						end
					end
				end
				S_CLOSE2: begin
					if (rx_valid) begin
						rx_done  <= is_delim;
						rx_error <= !is_delim;
						if (is_delim)
							rx_length <= count_q;
						state <= S_HUNT1;
					end
				end
				default: begin
					if (wb_rsp.ack) begin
						count_q <= count_q + 8'd1;
						state   <= S_CONTENT;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == S_CONTENT && rx_valid)
			wdata_q <= rx_byte;
	end

	// buffer write must finish well inside one serial byte time
	no_byte_during_write: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == S_WRITE) |-> !rx_valid)
		else $error("received byte while buffer write still pending");

endmodule

//--- source/msg_buffer.sv
//##########################################################################
// shared 256 x 8 message buffer behind a round-robin arbiter for three
// wishbone classic masters (host, encoder, decoder). ack follows the
// granted strobe by one clock, read data is registered
//##########################################################################
module msg_buffer (
	input  logic				sys_clk,
	input  logic				sys_rst_n,
	input  uart_frame_pkg::wb_req_t		host_req,
	input  uart_frame_pkg::wb_req_t		enc_req,
	input  uart_frame_pkg::wb_req_t		dec_req,
	output uart_frame_pkg::wb_rsp_t		host_rsp,
	output uart_frame_pkg::wb_rsp_t		enc_rsp,
	output uart_frame_pkg::wb_rsp_t		dec_rsp
);

	import uart_frame_pkg::*;

	wb_req_t	req_a [3];
	logic [2:0]	cyc_v;
	logic [1:0]	last_q;
	logic [1:0]	owner_q;
	logic		owned_q;
	logic		ack_q;
	logic [1:0]	ack_idx;
	logic [1:0]	c1;
	logic [1:0]	c2;
	logic [1:0]	pick;
	logic [1:0]	sel;
	logic		hold;
	logic		go;
	logic [7:0]	rd_q;
	logic [7:0]	mem [BUF_DEPTH];

	function automatic logic [1:0] next_of(input logic [1:0] i);
		return (i == 2'd2) ? 2'd0 : i + 2'd1;
	endfunction

	assign req_a[0] = host_req;
	assign req_a[1] = enc_req;
	assign req_a[2] = dec_req;
	assign cyc_v    = {dec_req.cyc, enc_req.cyc, host_req.cyc};

	// search starts after the master served last
	assign c1   = next_of(last_q);
	assign c2   = next_of(c1);
	assign pick = cyc_v[c1] ? c1 : (cyc_v[c2] ? c2 : last_q);

	assign hold = owned_q && cyc_v[owner_q];
	assign sel  = hold ? owner_q : pick;
	// no new access while the previous ack is out
	assign go   = cyc_v[sel] && req_a[sel].stb && !ack_q;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			last_q  <= 2'd2;
			owner_q <= '0;
			owned_q <= 1'b0;
			ack_q   <= 1'b0;
			ack_idx <= '0;
		end else begin
			owned_q <= hold || (|cyc_v);
			owner_q <= sel;
			ack_q   <= go;
			ack_idx <= sel;
			if (go)
				last_q <= sel;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (go && req_a[sel].we)
			mem[req_a[sel].adr] <= req_a[sel].dat;
		rd_q <= mem[req_a[sel].adr];
	end

	assign host_rsp = '{ack: ack_q && (ack_idx == 2'd0), dat: rd_q};
	assign enc_rsp  = '{ack: ack_q && (ack_idx == 2'd1), dat: rd_q};
	assign dec_rsp  = '{ack: ack_q && (ack_idx == 2'd2), dat: rd_q};

	// ack only reaches a master still in its cycle
	ack_to_active: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		ack_q |-> cyc_v[ack_idx])
		else $error("ack to a master without cyc");

endmodule

//--- source/uart_frame_top.sv
//##########################################################################
// top level of the framed-string UART transceiver
// host fills the transmit region over wishbone and pulses tx_start;
// received frames land in the receive region, length on rx_length
//##########################################################################
module uart_frame_top #(
	parameter int CLKS_PER_BIT = 16,
	parameter int MAX_LEN      = 64
) (
	input  logic				sys_clk,
	input  logic				sys_rst_n,
	input  uart_frame_pkg::wb_req_t		host_req,
	output uart_frame_pkg::wb_rsp_t		host_rsp,
	input  logic				tx_start,
	input  logic [7:0]			tx_length,
	output logic				tx_busy,
	output logic				tx_done,
	output logic				rx_done,
	output logic				rx_error,
	output logic [7:0]			rx_length,
	input  logic				uart_rxd,
	output logic				uart_txd
);

	import uart_frame_pkg::*;

	wb_req_t	enc_req;
	wb_rsp_t	enc_rsp;
	wb_req_t	dec_req;
	wb_rsp_t	dec_rsp;
	logic		byte_valid;
	logic [7:0]	byte_data;
	logic		byte_ready;
	logic		rx_valid;
	logic [7:0]	rx_byte;

	frame_encoder #(.MAX_LEN(MAX_LEN)) u_encoder (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.tx_start(tx_start), .tx_length(tx_length),
		.tx_busy(tx_busy), .tx_done(tx_done),
		.wb_req(enc_req), .wb_rsp(enc_rsp),
		.byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.tx_valid(byte_valid), .tx_data(byte_data), .tx_ready(byte_ready),
		.txd(uart_txd)
	);

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rxd(uart_rxd), .rx_valid(rx_valid), .rx_byte(rx_byte)
	);

	frame_decoder #(.MAX_LEN(MAX_LEN)) u_decoder (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rx_valid(rx_valid), .rx_byte(rx_byte),
		.wb_req(dec_req), .wb_rsp(dec_rsp),
		.rx_done(rx_done), .rx_error(rx_error), .rx_length(rx_length)
	);

	// arbitration order host, encoder, decoder
	msg_buffer u_buffer (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.host_req(host_req), .enc_req(enc_req), .dec_req(dec_req),
		.host_rsp(host_rsp), .enc_rsp(enc_rsp), .dec_rsp(dec_rsp)
	);

endmodule

//--- verification/frame_checker.sv
//##########################################################################
// checker for the transceiver testbench: holds the expected serial bytes
// and receive outcomes pushed by the testbench, decodes uart_txd at
// mid-bit and compares as each byte and status pulse arrives
//##########################################################################
module frame_checker #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic		sys_clk,
	input  logic		sys_rst_n,
	input  logic		txd,
	input  logic		tx_done,
	input  logic		rx_done,
	input  logic		rx_error,
	input  logic [7:0]	rx_length
);

	import uart_frame_pkg::*;

	logic [7:0]	exp_bytes [$];
	// one entry per frame, -1 for a frame the decoder must reject
	int		exp_rx [$];
	int		tx_done_owed = 0;
	int		err_count = 0;
	int		err_mark = 0;
	int		tests_run = 0;
	int		tests_failed = 0;

	function automatic void compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			err_count++;
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endfunction

	function automatic void note_failure(input string what);
		err_count++;
		$display("error at %0t: %s", $time, what);
	endfunction

	function automatic void push_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endfunction

	function automatic void expect_tx_done();
		tx_done_owed++;
	endfunction

	function automatic void expect_rx(input int len);
		exp_rx.push_back(len);
	endfunction

	function automatic void check_outcome();
		int want;
		if (exp_rx.size() == 0) begin
			note_failure("receive status pulsed with no frame expected");
		end else begin
			want = exp_rx.pop_front();
			if (rx_done && rx_error)
				note_failure("rx_done and rx_error high together");
			else if (want < 0 && rx_done)
				note_failure("rx_done for a frame that should be rejected");
			else if (want >= 0 && rx_error)
				note_failure($sformatf("rx_error for a good frame of length %0d", want));
			else if (rx_done) begin
				compare("rx_length", want, rx_length);
				if (int'(RX_BASE) + int'(rx_length) > BUF_DEPTH)
					note_failure("rx_length runs past the end of the buffer");
			end
		end
	endfunction

	function automatic void end_test(input string name);
		if (exp_bytes.size() != 0)
			note_failure($sformatf("%0d expected bytes never seen on uart_txd", exp_bytes.size()));
		if (exp_rx.size() != 0)
			note_failure($sformatf("%0d receive outcomes never reported", exp_rx.size()));
		if (tx_done_owed != 0)
			note_failure("tx_done missing for a started frame");
		exp_bytes.delete();
		exp_rx.delete();
		tx_done_owed = 0;
		tests_run++;
		if (err_count != err_mark) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_count - err_mark);
		end else begin
			$display("test %0d %s: passed", tests_run, name);
		end
		err_mark = err_count;
	endfunction

	function automatic void report_counts();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
	endfunction

	// serial decoder on the transmit line
	initial begin : serial_monitor
		logic [7:0] got;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !txd) begin
				repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
				if (txd)
					note_failure("start bit on uart_txd ended before its midpoint");
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					got[i] = txd;
				end
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				if (!txd)
					note_failure("stop bit missing on uart_txd");
				if (exp_bytes.size() == 0)
					note_failure($sformatf("unexpected byte %h on uart_txd", got));
				else
					compare("uart_txd byte", exp_bytes.pop_front(), got);
			end
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (tx_done) begin
				if (tx_done_owed == 0)
					note_failure("tx_done pulsed with no frame in flight");
				else
					tx_done_owed--;
			end
			if (rx_done || rx_error)
				check_outcome();
		end
	end

endmodule

//--- verification/tb_uart_frame.sv
//##########################################################################
// testbench for the framed-string UART transceiver
// host tasks fill and read the buffer, frames run in loopback or are
// bit-banged onto the receive line; frame_checker does the comparing
//##########################################################################
module tb_uart_frame;

	import uart_frame_pkg::*;

	localparam int CLKS_PER_BIT = 16;
	localparam int MAX_LEN      = 64;
	localparam int BYTE_CYCLES  = 10 * CLKS_PER_BIT;

	logic		sys_clk;
	logic		sys_rst_n;
	wb_req_t	host_req;
	wb_rsp_t	host_rsp;
	logic		tx_start;
	logic [7:0]	tx_length;
	logic		tx_busy;
	logic		tx_done;
	logic		rx_done;
	logic		rx_error;
	logic [7:0]	rx_length;
	logic		uart_rxd;
	logic		uart_txd;
	logic		loopback;
	logic		inj_line;
	logic		frame_over;
	integer		seed = 32'h2815;
	int		limit_cycles = 0;
	int		len_a;
	int		len_b;
	int		len_c;
	int		reads;
	logic [7:0]	payload [256];
	logic [7:0]	exp_frame [$];

	// receive line from the transmitter or from the injection task
	assign uart_rxd = loopback ? uart_txd : inj_line;

	uart_frame_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .MAX_LEN(MAX_LEN)) UUT (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.host_req(host_req), .host_rsp(host_rsp),
		.tx_start(tx_start), .tx_length(tx_length),
		.tx_busy(tx_busy), .tx_done(tx_done),
		.rx_done(rx_done), .rx_error(rx_error), .rx_length(rx_length),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd)
	);

	frame_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) chk (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .txd(uart_txd), .tx_done(tx_done),
		.rx_done(rx_done), .rx_error(rx_error), .rx_length(rx_length)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// expected line bytes: two delimiters, payload, two delimiters
	function automatic void build_frame(input int len);
		int n;
		n = (len > MAX_LEN) ? MAX_LEN : len;
		exp_frame.delete();
		exp_frame.push_back(FRAME_DELIM);
		exp_frame.push_back(FRAME_DELIM);
		for (int i = 0; i < n; i++)
			exp_frame.push_back(payload[i]);
		exp_frame.push_back(FRAME_DELIM);
		exp_frame.push_back(FRAME_DELIM);
	endfunction

	task automatic host_transfer(input logic we, input logic [7:0] adr,
			input logic [7:0] wdat, output logic [7:0] rdat);
		@(negedge sys_clk);
		host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge sys_clk);
		while (!host_rsp.ack)
			@(negedge sys_clk);
		rdat = host_rsp.dat;
		// cyc stays up across the ack edge
		@(negedge sys_clk);
		host_req = '0;
	endtask

	task automatic host_write(input logic [7:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		host_transfer(1'b1, adr, dat, unused);
	endtask

	task automatic host_read(input logic [7:0] adr, output logic [7:0] dat);
		host_transfer(1'b0, adr, 8'h00, dat);
	endtask

	task automatic draw_payload(input int len);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = 8'($random(seed));
			while (b == FRAME_DELIM)
				b = 8'($random(seed));
			payload[i] = b;
		end
	endtask

	task automatic load_payload(input int len);
		for (int i = 0; i < len; i++)
			host_write(TX_BASE + 8'(i), payload[i]);
	endtask

	task automatic check_rx_region(input int len);
		logic [7:0] d;
		for (int i = 0; i < len; i++) begin
			host_read(RX_BASE + 8'(i), d);
			chk.compare("receive region byte", payload[i], d);
		end
	endtask

	task automatic expect_loopback(input int len);
		build_frame(len);
		foreach (exp_frame[i])
			chk.push_byte(exp_frame[i]);
		chk.expect_tx_done();
		chk.expect_rx(len);
	endtask

	task automatic start_frame(input int len);
		@(negedge sys_clk);
		tx_start  = 1'b1;
		tx_length = 8'(len);
		@(negedge sys_clk);
		tx_start  = 1'b0;
	endtask

	task automatic wait_tx_done(input int len);
		int budget;
		int n;
		budget = (len + 4) * BYTE_CYCLES * 2 + 200;
		n = 0;
		@(negedge sys_clk);
		while (!tx_done && n < budget) begin
			@(negedge sys_clk);
			n++;
		end
		if (!tx_done)
			chk.note_failure($sformatf("tx_done missing after %0d cycles", budget));
	endtask

	// 8N1 byte on the injection line, LSB first
	task automatic inject_byte(input logic [7:0] b);
		inj_line = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			inj_line = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		inj_line = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic inject_text(input string s);
		for (int i = 0; i < s.len(); i++)
			inject_byte(s[i]);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge sys_clk);
		$display("error: watchdog expired after %0d cycles, run did not finish", limit_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : test_sequence
		logic [7:0] d;
		sys_rst_n  = 1'b0;
		host_req   = '0;
		tx_start   = 1'b0;
		tx_length  = '0;
		loopback   = 1'b1;
		inj_line   = 1'b1;
		frame_over = 1'b0;
		reads      = 0;
		len_a = 1 + int'($unsigned($random(seed)) % MAX_LEN);
		len_b = 1 + int'($unsigned($random(seed)) % MAX_LEN);
		len_c = 1 + int'($unsigned($random(seed)) % MAX_LEN);
		// every line byte of every test, twice over, plus host traffic
		limit_cycles = (len_a + len_b + len_c + 16 + 6 + (MAX_LEN + 3) + 9)
			* BYTE_CYCLES * 2 + 8000;
		repeat (4) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		@(negedge sys_clk);
		chk.compare("uart_txd", 1, uart_txd);
		chk.compare("tx_busy", 0, tx_busy);
		chk.compare("tx_done", 0, tx_done);
		chk.compare("rx_done", 0, rx_done);
		chk.compare("rx_error", 0, rx_error);
		chk.compare("host ack", 0, host_rsp.ack);
		host_write(8'd250, 8'hc3);
		host_read(8'd250, d);
		chk.compare("host read back", 8'hc3, d);
		chk.end_test("reset state and host access");

		draw_payload(len_a);
		load_payload(len_a);
		expect_loopback(len_a);
		start_frame(len_a);
		wait_tx_done(len_a);
		idle_cycles(2 * CLKS_PER_BIT);
		check_rx_region(len_a);
		chk.end_test($sformatf("loopback frame of %0d bytes", len_a));

		expect_loopback(0);
		start_frame(0);
		wait_tx_done(0);
		idle_cycles(2 * CLKS_PER_BIT);
		chk.end_test("empty frame");

		loopback = 1'b0;
		chk.expect_rx(-1);
		inject_text("&&ab&x");
		idle_cycles(2 * CLKS_PER_BIT);
		// closing pair left off, it would open a new frame
		chk.expect_rx(-1);
		inject_byte(FRAME_DELIM);
		inject_byte(FRAME_DELIM);
		for (int i = 0; i <= MAX_LEN; i++)
			inject_byte(8'h41 + 8'(i % 26));
		idle_cycles(2 * CLKS_PER_BIT);
		draw_payload(5);
		chk.expect_rx(5);
		inject_byte(FRAME_DELIM);
		inject_byte(FRAME_DELIM);
		for (int i = 0; i < 5; i++)
			inject_byte(payload[i]);
		inject_byte(FRAME_DELIM);
		inject_byte(FRAME_DELIM);
		idle_cycles(2 * CLKS_PER_BIT);
		check_rx_region(5);
		loopback = 1'b1;
		chk.end_test("malformed frames then a good one");

		draw_payload(len_b);
		load_payload(len_b);
		expect_loopback(len_b);
		start_frame(len_b);
		idle_cycles(3 * CLKS_PER_BIT);
		chk.compare("tx_busy", 1, tx_busy);
		start_frame(len_b / 2 + 1);
		wait_tx_done(len_b);
		idle_cycles(BYTE_CYCLES);
		chk.compare("tx_busy", 0, tx_busy);
		chk.end_test("start while busy is ignored");

		draw_payload(len_c);
		load_payload(len_c);
		expect_loopback(len_c);
		fork
			begin
				start_frame(len_c);
				wait_tx_done(len_c);
				frame_over = 1'b1;
			end
			begin
				while (!frame_over) begin
					host_read(TX_BASE + 8'(reads % len_c), d);
					chk.compare("host read during frame", payload[reads % len_c], d);
					reads++;
				end
			end
		join
		idle_cycles(2 * CLKS_PER_BIT);
		if (reads == 0)
			chk.note_failure("no host read completed during the frame");
		check_rx_region(len_c);
		chk.end_test("host reads during a frame");

		chk.report_counts();
		if (chk.err_count == 0 && chk.tests_failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- vlog.f
source/uart_frame_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_encoder.sv
source/frame_decoder.sv
source/msg_buffer.sv
source/uart_frame_top.sv
verification/frame_checker.sv
verification/tb_uart_frame.sv

//--- Makefile
# Verilator flow for the framed-string UART transceiver
# override any variable on the command line, e.g. make sim TOP=tb_uart_frame

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= tb_uart_frame
LINT_TOP   ?= uart_frame_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
